// ==== common/body_mem_pkg.sv ====
package body_mem_pkg;

	import nbody_pkg::*;

	// 16 body records
	localparam int BODY_IDX_W = 4;

	typedef logic [BODY_IDX_W-1:0] body_idx_t;

	// per-vector write enables
	typedef struct packed {
		logic pos;
		logic vel;
		logic acc;
	} field_mask_t;

	// one access to the body table
	// mask and wdata only matter when write is set
	typedef struct packed {
		logic        valid;
		logic        write;
		body_idx_t   idx;
		field_mask_t mask;
		body_rec_t   wdata;
	} mem_req_t;

	// peers sharing the table, listed by priority
	typedef enum logic [1:0] {
		REQ_HOST,
		REQ_POS,
		REQ_VEL
	} req_id_t;

endpackage

// ==== common/nbody_pkg.sv ====
package nbody_pkg;

	// signed q16.16, 16 integer bits and 16 fraction bits
	typedef logic signed [31:0] fix_t;

	// one spatial vector, x in the top word
	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vec3_t;

	// full body record as stored in the table
	typedef struct packed {
		vec3_t pos;
		vec3_t vel;
		vec3_t acc;
	} body_rec_t;

	// which half of the euler step a stage performs
	typedef enum logic {
		VEL_STAGE,
		POS_STAGE
	} stage_kind_t;

	// cur + rate * dt with dt = 2^-shift
	// arithmetic shift rounds toward minus infinity, sum wraps at 32 bits
	function automatic fix_t fix_advance(fix_t cur, fix_t rate, int shift);
		return cur + (rate >>> shift);
	endfunction

	// same rule applied per component
	function automatic vec3_t vec_advance(vec3_t cur, vec3_t rate, int shift);
		vec3_t res;
		res.x = fix_advance(cur.x, rate.x, shift);
		res.y = fix_advance(cur.y, rate.y, shift);
		res.z = fix_advance(cur.z, rate.z, shift);
		return res;
	endfunction

endpackage

// ==== dv/gravsim_model.svh ====
`ifndef GRAVSIM_MODEL_SVH
`define GRAVSIM_MODEL_SVH

// galois lfsr, right shifting, one step per bit
function automatic logic [31:0] lfsr_step(logic [31:0] s);
	logic [31:0] n;
	n = s >> 1;
	if (s[0])
		n = n ^ 32'h8020_0003;
	return n;
endfunction

// nbits of lfsr output, sign extended into a small q16.16 value
task automatic draw_fix(input int nbits, output fix_t v);
	logic [31:0] bits;
	bits = '0;
	for (int b = 0; b < nbits; b++)
	begin
		lfsr_state = lfsr_step(lfsr_state);
		bits[b] = lfsr_state[0];
	end
	v = fix_t'(bits << (32 - nbits)) >>> (32 - nbits);
endtask

// rate * 2^-sh, floor division done in 64 bits
function automatic fix_t scaled_rate(fix_t rate, int sh);
	longint num;
	longint den;
	longint q;
	num = longint'(rate);
	den = longint'(1) << sh;
	q = num / den;
	// division truncates toward zero, step down for negative remainders
	if ((num % den != 0) && (num < 0))
		q = q - 1;
	return q[31:0];
endfunction

// 32-bit wrapping sum
function automatic fix_t wrap_add(fix_t a, fix_t b);
	longint s;
	s = longint'(a) + longint'(b);
	return s[31:0];
endfunction

function automatic vec3_t integrate_vec(vec3_t cur, vec3_t rate, int sh);
	vec3_t n;
	n.x = wrap_add(cur.x, scaled_rate(rate.x, sh));
	n.y = wrap_add(cur.y, scaled_rate(rate.y, sh));
	n.z = wrap_add(cur.z, scaled_rate(rate.z, sh));
	return n;
endfunction

// semi-implicit euler: vel first, pos from the new vel, acc consumed
function automatic body_rec_t euler_step(body_rec_t r, int sh);
	body_rec_t n;
	n = r;
	n.vel = integrate_vec(r.vel, r.acc, sh);
	n.pos = integrate_vec(r.pos, n.vel, sh);
	n.acc = '0;
	return n;
endfunction

// host write seen through the field mask
function automatic body_rec_t merge_fields(body_rec_t old, body_rec_t nw, field_mask_t m);
	body_rec_t r;
	r = old;
	if (m.pos)
		r.pos = nw.pos;
	if (m.vel)
		r.vel = nw.vel;
	if (m.acc)
		r.acc = nw.acc;
	return r;
endfunction

task automatic check_rec(input string sig, input body_rec_t exp, input body_rec_t act);
	if (act !== exp)
	begin
		$display("error at %0t: %s expected %h got %h", $time, sig, exp, act);
		stop_run();
	end
endtask

task automatic check_flag(input string sig, input logic exp, input logic act);
	if (act !== exp)
	begin
		$display("error at %0t: %s expected %b got %b", $time, sig, exp, act);
		stop_run();
	end
endtask

`endif

// ==== dv/gravsim_tb.sv ====
`timescale 1ns/10ps

module gravsim_tb
	import nbody_pkg::*;
	import body_mem_pkg::*;
;

	localparam int DT_SHIFT = 6;
	localparam int NUM_BODIES = 16;
	localparam int N_ROWS = 5;
	localparam field_mask_t MASK_ALL = 3'b111;
	// pos, vel, acc from msb down
	localparam field_mask_t MASK_VEL = 3'b010;

	// one stimulus row
	typedef struct packed {
		logic [4:0] count;
		logic [3:0] steps;
		logic       from_lfsr;
	} row_t;

	localparam row_t ROWS [N_ROWS] = '{
		'{count: 5'd1,  steps: 4'd2, from_lfsr: 1'b0},
		'{count: 5'd5,  steps: 4'd1, from_lfsr: 1'b1},
		'{count: 5'd16, steps: 4'd2, from_lfsr: 1'b1},
		'{count: 5'd0,  steps: 4'd1, from_lfsr: 1'b1},
		'{count: 5'd3,  steps: 4'd3, from_lfsr: 1'b0}
	};

	logic                CLK;
	logic                RESET;
	logic                start_i;
	logic [BODY_IDX_W:0] body_count_i;
	logic                busy_o;
	logic                done_o;
	mem_req_t            host_req_i;
	logic                host_rvalid_o;
	body_rec_t           host_rdata_o;

	logic [31:0] lfsr_state = 32'h38a2;
	int          cycles = 0;
	int          cycle_limit = 0;
	// expected table contents
	body_rec_t   exp_mem [NUM_BODIES];

	gravsim_top #(.DT_SHIFT(DT_SHIFT)) dut0 (
		.CLK(CLK), .RESET(RESET), .start_i(start_i), .body_count_i(body_count_i),
		.busy_o(busy_o), .done_o(done_o), .host_req_i(host_req_i),
		.host_rvalid_o(host_rvalid_o), .host_rdata_o(host_rdata_o)
	);

	task automatic stop_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	`include "gravsim_model.svh"

	// 4 ns clock
	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// watchdog
	always @(posedge CLK)
	begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			stop_run();
		end
	end

	// 20 cycles per body per step, plus slack for reset and host traffic
	function automatic int run_budget();
		int total;
		total = 200;
		for (int r = 0; r < N_ROWS; r++)
			total += 20 * int'(ROWS[r].count) * int'(ROWS[r].steps);
		return total;
	endfunction

	// inputs change 1 ns after the edge, outputs sampled there too
	task automatic wait_cycle();
		@(posedge CLK);
		#1;
	endtask

	function automatic vec3_t mk_vec(fix_t x, fix_t y, fix_t z);
		vec3_t v;
		v.x = x;
		v.y = y;
		v.z = z;
		return v;
	endfunction

	// hand-picked records, negative rates check the floor rounding
	function automatic body_rec_t fixed_rec(int k);
		body_rec_t r;
		case (k)
			0:
			begin
				r.pos = mk_vec(32'sh0001_0000, -32'sh0002_8000, 32'sh0000_4000);
				r.vel = mk_vec(32'sh0000_8000, 32'sh0, -32'sh0000_c000);
				r.acc = mk_vec(-32'sd65, 32'sd130, 32'sh0001_0000);
			end
			1:
			begin
				r.pos = mk_vec(-32'sh0003_0000, 32'sh0007_2000, -32'sd1);
				r.vel = mk_vec(-32'sd1, 32'sd63, -32'sd64);
				r.acc = '0;
			end
			default:
			begin
				r.pos = mk_vec(32'sh0000_0101, -32'sh0000_0fff, 32'sh0004_0000);
				r.vel = mk_vec(-32'sh0001_0001, 32'sh0000_0040, 32'sd0);
				r.acc = mk_vec(-32'sh0002_0000, -32'sd127, 32'sd127);
			end
		endcase
		return r;
	endfunction

	task automatic rand_rec(output body_rec_t r);
		draw_fix(20, r.pos.x);
		draw_fix(20, r.pos.y);
		draw_fix(20, r.pos.z);
		draw_fix(20, r.vel.x);
		draw_fix(20, r.vel.y);
		draw_fix(20, r.vel.z);
		draw_fix(18, r.acc.x);
		draw_fix(18, r.acc.y);
		draw_fix(18, r.acc.z);
	endtask

	// one-cycle host write strobe, model follows the mask
	task automatic write_body(input body_idx_t idx, input field_mask_t m, input body_rec_t r);
		host_req_i.valid = 1'b1;
		host_req_i.write = 1'b1;
		host_req_i.idx   = idx;
		host_req_i.mask  = m;
		host_req_i.wdata = r;
		wait_cycle();
		host_req_i = '0;
		exp_mem[idx] = merge_fields(exp_mem[idx], r, m);
	endtask

	// read strobe, data and rvalid one cycle later, rvalid gone after that
	task automatic verify_body(input body_idx_t idx);
		host_req_i.valid = 1'b1;
		host_req_i.write = 1'b0;
		host_req_i.idx   = idx;
		wait_cycle();
		host_req_i = '0;
		check_flag("host_rvalid_o", 1'b1, host_rvalid_o);
		check_rec($sformatf("host_rdata_o (body %0d)", idx), exp_mem[idx], host_rdata_o);
		wait_cycle();
		check_flag("host_rvalid_o", 1'b0, host_rvalid_o);
		// no stray done pulse once the step is over
		check_flag("done_o", 1'b0, done_o);
	endtask

	// start strobe, watch busy until the single done pulse
	task automatic run_step(input int cnt);
		body_count_i = cnt[BODY_IDX_W:0];
		start_i = 1'b1;
		wait_cycle();
		start_i = 1'b0;
		if (cnt == 0)
			check_flag("done_o", 1'b1, done_o);
		else
		begin
			while (done_o !== 1'b1)
			begin
				check_flag("busy_o", 1'b1, busy_o);
				wait_cycle();
			end
		end
		// busy falls together with done
		check_flag("busy_o", 1'b0, busy_o);
		wait_cycle();
		check_flag("done_o", 1'b0, done_o);
		check_flag("busy_o", 1'b0, busy_o);
		for (int i = 0; i < cnt; i++)
			exp_mem[i] = euler_step(exp_mem[i], DT_SHIFT);
	endtask

	initial
	begin
		body_rec_t rec;
		int        cnt;
		int        n_steps;
		cycle_limit  = run_budget();
		RESET        = 1'b1;
		start_i      = 1'b0;
		body_count_i = '0;
		host_req_i   = '0;
		repeat (5) @(posedge CLK);
		#1;
		RESET = 1'b0;
		check_flag("busy_o", 1'b0, busy_o);
		check_flag("done_o", 1'b0, done_o);

		// host round trip, then a vel-only write
		rand_rec(rec);
		write_body(4'd2, MASK_ALL, rec);
		verify_body(4'd2);
		rand_rec(rec);
		write_body(4'd2, MASK_VEL, rec);
		verify_body(4'd2);

		for (int r = 0; r < N_ROWS; r++)
		begin
			cnt     = int'(ROWS[r].count);
			n_steps = int'(ROWS[r].steps);
			// whole table reloaded so bodies above the count are known too
			for (int i = 0; i < NUM_BODIES; i++)
			begin
				if (ROWS[r].from_lfsr)
					rand_rec(rec);
				else
					rec = fixed_rec(i % 3);
				write_body(body_idx_t'(i), MASK_ALL, rec);
			end
			for (int s = 0; s < n_steps; s++)
			begin
				run_step(cnt);
				for (int i = 0; i < NUM_BODIES; i++)
					verify_body(body_idx_t'(i));
			end
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+dv
common/nbody_pkg.sv
common/body_mem_pkg.sv
logic/body_mem.sv
logic/mem_arbiter.sv
integrator/euler_stage.sv
integrator/step_sequencer.sv
logic/gravsim_top.sv
dv/gravsim_tb.sv

// ==== integrator/euler_stage.sv ====
`timescale 1ns/10ps

module euler_stage
	import nbody_pkg::*;
	import body_mem_pkg::*;
#(
	parameter int          DT_SHIFT = 6,
	parameter stage_kind_t KIND     = VEL_STAGE
)
(
	input  logic      CLK,
	input  logic      RESET,
	input  logic      launch_i,
	input  body_idx_t idx_i,
	output logic      busy_o,
	output logic      done_o,
	output body_idx_t done_idx_o,
	output mem_req_t  req_o,
	input  logic      gnt_i,
	input  logic      rvalid_i,
	input  body_rec_t rdata_i
);

	// vel stage writes vel only
	// pos stage writes pos and clears the consumed acc
	localparam field_mask_t WR_MASK = (KIND == VEL_STAGE) ?
		field_mask_t'{pos: 1'b0, vel: 1'b1, acc: 1'b0} :
		field_mask_t'{pos: 1'b1, vel: 1'b0, acc: 1'b1};

	typedef enum logic [1:0] {
		S_IDLE,
		S_RD_REQ,
		S_RD_WAIT,
		S_WR_REQ
	} state_t;

	state_t    state;
	body_idx_t idx_q;
	body_rec_t wdata_q;
	body_rec_t next_rec;

	// read -> compute -> write, each step may stall on the arbiter
	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			state  <= S_IDLE;
			done_o <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			case (state)
				S_IDLE:
					if (launch_i)
						state <= S_RD_REQ;
				S_RD_REQ:
					if (gnt_i)
						state <= S_RD_WAIT;
				S_RD_WAIT:
					if (rvalid_i)
						state <= S_WR_REQ;
				S_WR_REQ:
					if (gnt_i)
					begin
						// write is in the table once done is seen
						state  <= S_IDLE;
						done_o <= 1'b1;
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// new target vector, all other fields left zero
	always_comb
	begin
		next_rec = '0;
		if (KIND == VEL_STAGE)
			next_rec.vel = vec_advance(rdata_i.vel, rdata_i.acc, DT_SHIFT);
		else
			next_rec.pos = vec_advance(rdata_i.pos, rdata_i.vel, DT_SHIFT);
	end

	always_ff @(posedge CLK)
	begin
		if (state == S_IDLE && launch_i)
			idx_q <= idx_i;
		if (state == S_RD_WAIT && rvalid_i)
			wdata_q <= next_rec;
	end

	// request is a pure function of state, so it holds until granted
	always_comb
	begin
		req_o       = '0;
		req_o.valid = (state == S_RD_REQ) || (state == S_WR_REQ);
		req_o.write = (state == S_WR_REQ);
		req_o.idx   = idx_q;
		if (state == S_WR_REQ)
		begin
			req_o.mask  = WR_MASK;
			req_o.wdata = wdata_q;
		end
	end

	assign busy_o     = (state != S_IDLE);
	assign done_idx_o = idx_q;

	// sequencer must wait for idle
	a_no_launch_busy : assert property (
		@(posedge CLK) disable iff (RESET)
		launch_i |-> !busy_o
	);

	// read data only returns to a stage that asked for it
	a_rvalid_expected : assert property (
		@(posedge CLK) disable iff (RESET)
		rvalid_i |-> (state == S_RD_WAIT)
	);

endmodule

// ==== integrator/step_sequencer.sv ====
`timescale 1ns/10ps

module step_sequencer
	import body_mem_pkg::*;
(
	input  logic                CLK,
	input  logic                RESET,
	input  logic                start_i,
	input  logic [BODY_IDX_W:0] body_count_i,
	output logic                busy_o,
	output logic                done_o,
	output logic                vel_launch_o,
	output body_idx_t           vel_idx_o,
	input  logic                vel_busy_i,
	input  logic                vel_done_i,
	input  body_idx_t           vel_done_idx_i,
	output logic                pos_launch_o,
	output body_idx_t           pos_idx_o,
	input  logic                pos_busy_i,
	input  logic                pos_done_i,
	input  body_idx_t           pos_done_idx_i
);

	logic [BODY_IDX_W:0] count_q;
	logic [BODY_IDX_W:0] next_idx;
	logic                pend_valid;
	logic                pend_valid_d;
	body_idx_t           pend_idx;
	body_idx_t           pend_idx_d;
	logic                pos_free;
	logic                last_done;

	assign pos_free = !pos_busy_i;

	// pending body goes first, else a fresh vel result goes straight through
	assign pos_launch_o = pos_free && (pend_valid || vel_done_i);
	assign pos_idx_o    = pend_valid ? pend_idx : vel_done_idx_i;

	// one-entry slot between the stages
	always_comb
	begin
		pend_valid_d = pend_valid;
		pend_idx_d   = pend_idx;
		if (pend_valid && pos_free)
		begin
			// slot drains, a new vel result may refill it
			pend_valid_d = vel_done_i;
			pend_idx_d   = vel_done_idx_i;
		end
		else if (!pend_valid && vel_done_i && !pos_free)
		begin
			pend_valid_d = 1'b1;
			pend_idx_d   = vel_done_idx_i;
		end
	end

	// hold off vel launches while the slot is or is about to be full
	assign vel_launch_o = busy_o && (next_idx < count_q) && !vel_busy_i && !pend_valid_d;
	assign vel_idx_o    = next_idx[BODY_IDX_W-1:0];

	// bodies finish in order, so the last pos write ends the step
	assign last_done = pos_done_i && ({1'b0, pos_done_idx_i} == count_q - 1'b1);

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			busy_o     <= 1'b0;
			done_o     <= 1'b0;
			pend_valid <= 1'b0;
		end
		else
		begin
			done_o     <= 1'b0;
			pend_valid <= pend_valid_d;
			if (start_i && !busy_o)
			begin
				count_q  <= body_count_i;
				next_idx <= '0;
				// empty table finishes at once
				if (body_count_i == '0)
					done_o <= 1'b1;
				else
					busy_o <= 1'b1;
			end
			else if (busy_o)
			begin
				if (vel_launch_o)
					next_idx <= next_idx + 1'b1;
				if (last_done)
				begin
					busy_o <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		pend_idx <= pend_idx_d;
	end

	// a vel result never arrives with nowhere to go
	a_no_lost_body : assert property (
		@(posedge CLK) disable iff (RESET)
		vel_done_i |-> (!pend_valid || pos_free)
	);

endmodule

// ==== logic/body_mem.sv ====
`timescale 1ns/10ps

module body_mem
	import nbody_pkg::*;
	import body_mem_pkg::*;
(
	input  logic      CLK,
	input  logic      RESET,
	input  mem_req_t  req_i,
	output body_rec_t rdata_o
);

	// record table, contents undefined until loaded
	body_rec_t mem [2**BODY_IDX_W];

	always_ff @(posedge CLK)
	begin
		// masked write, untouched vectors keep their value
		if (req_i.valid && req_i.write)
		begin
			if (req_i.mask.pos)
				mem[req_i.idx].pos <= req_i.wdata.pos;
			if (req_i.mask.vel)
				mem[req_i.idx].vel <= req_i.wdata.vel;
			if (req_i.mask.acc)
				mem[req_i.idx].acc <= req_i.wdata.acc;
		end
		// read data lands one cycle after the request
		if (req_i.valid && !req_i.write)
			rdata_o <= mem[req_i.idx];
	end

	// no requester should ever issue a write that changes nothing
	a_write_has_mask : assert property (
		@(posedge CLK) disable iff (RESET)
		(req_i.valid && req_i.write) |-> (req_i.mask != '0)
	);

endmodule

// ==== logic/gravsim_top.sv ====
`timescale 1ns/10ps

module gravsim_top
	import nbody_pkg::*;
	import body_mem_pkg::*;
#(
	parameter int DT_SHIFT = 6
)
(
	input  logic                CLK,
	input  logic                RESET,
	input  logic                start_i,
	input  logic [BODY_IDX_W:0] body_count_i,
	output logic                busy_o,
	output logic                done_o,
	input  mem_req_t            host_req_i,
	output logic                host_rvalid_o,
	output body_rec_t           host_rdata_o
);

	mem_req_t  mem_req;
	body_rec_t mem_rdata;
	body_rec_t rd_data;

	// stage side of the arbiter
	mem_req_t  vel_req;
	mem_req_t  pos_req;
	logic      vel_gnt;
	logic      pos_gnt;
	logic      vel_rvalid;
	logic      pos_rvalid;

	// sequencer to stage control
	logic      vel_launch;
	body_idx_t vel_idx;
	logic      vel_busy;
	logic      vel_done;
	body_idx_t vel_done_idx;
	logic      pos_launch;
	body_idx_t pos_idx;
	logic      pos_busy;
	logic      pos_done;
	body_idx_t pos_done_idx;

	// host sees the shared read bus
	assign host_rdata_o = rd_data;

	body_mem mem0 (
		.CLK(CLK), .RESET(RESET), .req_i(mem_req), .rdata_o(mem_rdata)
	);

	mem_arbiter arb0 (
		.CLK(CLK), .RESET(RESET),
		.host_req_i(host_req_i), .pos_req_i(pos_req), .vel_req_i(vel_req),
		.pos_gnt_o(pos_gnt), .vel_gnt_o(vel_gnt),
		.mem_req_o(mem_req), .mem_rdata_i(mem_rdata),
		.host_rvalid_o(host_rvalid_o), .pos_rvalid_o(pos_rvalid),
		.vel_rvalid_o(vel_rvalid), .rdata_o(rd_data)
	);

	step_sequencer seq0 (
		.CLK(CLK), .RESET(RESET), .start_i(start_i), .body_count_i(body_count_i),
		.busy_o(busy_o), .done_o(done_o),
		.vel_launch_o(vel_launch), .vel_idx_o(vel_idx), .vel_busy_i(vel_busy),
		.vel_done_i(vel_done), .vel_done_idx_i(vel_done_idx),
		.pos_launch_o(pos_launch), .pos_idx_o(pos_idx), .pos_busy_i(pos_busy),
		.pos_done_i(pos_done), .pos_done_idx_i(pos_done_idx)
	);

	// v += a * dt
	euler_stage #(.DT_SHIFT(DT_SHIFT), .KIND(VEL_STAGE)) vel_stage0 (
		.CLK(CLK), .RESET(RESET), .launch_i(vel_launch), .idx_i(vel_idx),
		.busy_o(vel_busy), .done_o(vel_done), .done_idx_o(vel_done_idx),
		.req_o(vel_req), .gnt_i(vel_gnt), .rvalid_i(vel_rvalid), .rdata_i(rd_data)
	);

	// p += v_new * dt, acc cleared
	euler_stage #(.DT_SHIFT(DT_SHIFT), .KIND(POS_STAGE)) pos_stage0 (
		.CLK(CLK), .RESET(RESET), .launch_i(pos_launch), .idx_i(pos_idx),
		.busy_o(pos_busy), .done_o(pos_done), .done_idx_o(pos_done_idx),
		.req_o(pos_req), .gnt_i(pos_gnt), .rvalid_i(pos_rvalid), .rdata_i(rd_data)
	);

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter
	import nbody_pkg::*;
	import body_mem_pkg::*;
(
	input  logic      CLK,
	input  logic      RESET,
	input  mem_req_t  host_req_i,
	input  mem_req_t  pos_req_i,
	input  mem_req_t  vel_req_i,
	output logic      pos_gnt_o,
	output logic      vel_gnt_o,
	output mem_req_t  mem_req_o,
	input  body_rec_t mem_rdata_i,
	output logic      host_rvalid_o,
	output logic      pos_rvalid_o,
	output logic      vel_rvalid_o,
	output body_rec_t rdata_o
);

	req_id_t sel_id;
	req_id_t rd_id;
	logic    rd_pend;

	// fixed priority, host > pos > vel
	// host never waits, so it has no grant line
	always_comb
	begin
		mem_req_o = '0;
		sel_id    = REQ_HOST;
		pos_gnt_o = 1'b0;
		vel_gnt_o = 1'b0;
		if (host_req_i.valid)
			mem_req_o = host_req_i;
		else if (pos_req_i.valid)
		begin
			mem_req_o = pos_req_i;
			sel_id    = REQ_POS;
			pos_gnt_o = 1'b1;
		end
		else if (vel_req_i.valid)
		begin
			mem_req_o = vel_req_i;
			sel_id    = REQ_VEL;
			vel_gnt_o = 1'b1;
		end
	end

	// remember who read, data comes back next cycle
	always_ff @(posedge CLK)
	begin
		if (RESET)
			rd_pend <= 1'b0;
		else
			rd_pend <= mem_req_o.valid && !mem_req_o.write;
	end

	always_ff @(posedge CLK)
	begin
		rd_id <= sel_id;
	end

	// steer the single return strobe
	assign host_rvalid_o = rd_pend && (rd_id == REQ_HOST);
	assign pos_rvalid_o  = rd_pend && (rd_id == REQ_POS);
	assign vel_rvalid_o  = rd_pend && (rd_id == REQ_VEL);

	// read bus is shared, rvalid tells each peer when it is theirs
	assign rdata_o = mem_rdata_i;

	// a vel request left waiting stays as it was
	a_vel_req_held : assert property (
		@(posedge CLK) disable iff (RESET)
		(vel_req_i.valid && !vel_gnt_o) |=> $stable(vel_req_i)
	);

	// host traffic only while both stages are quiet
	a_host_alone : assert property (
		@(posedge CLK) disable iff (RESET)
		host_req_i.valid |-> !(pos_req_i.valid || vel_req_i.valid)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the gravsim testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module gravsim_tb -o gravsim_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/gravsim_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi

echo "simulation finished"
exit 0
